// ==== source/llm_int8_pkg.sv ====
package llm_int8_pkg;

    // element widths
    localparam int DATA_WIDTH = 16;
    localparam int SMALL_WIDTH = 8;

    // block geometry
    // activation block is IN_PARALLELISM rows by IN_SIZE columns
    localparam int IN_SIZE = 4;
    localparam int IN_PARALLELISM = 4;
    localparam int WEIGHT_PARALLELISM = 1;
    localparam int IN_DEPTH = 3;

    // 2x product width plus growth for IN_SIZE * IN_DEPTH terms
    localparam int ACC_WIDTH = 2 * DATA_WIDTH + 4;

    // elements per beat
    localparam int N_DATA = IN_PARALLELISM * IN_SIZE;
    localparam int N_WEIGHT = IN_SIZE * WEIGHT_PARALLELISM;
    localparam int N_OUT = IN_PARALLELISM * WEIGHT_PARALLELISM;

    // beat counter width inside the cores
    localparam int CNT_WIDTH = $clog2(IN_DEPTH);

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [SMALL_WIDTH-1:0] small_t;
    typedef logic signed [ACC_WIDTH-1:0] acc_t;

    // values inside this range take the int8 path
    localparam data_t SMALL_MIN = -16'sd128;
    localparam data_t SMALL_MAX = 16'sd127;

endpackage

// ==== source/outlier_split.sv ====
`timescale 1ns/10ps

// data element (r, k) sits at index r*IN_SIZE + k
// weight element (k, c) sits at index c*IN_SIZE + k
module outlier_split (
    input  logic                 clk,
    input  logic                 rst,

    input  llm_int8_pkg::data_t  data_in [llm_int8_pkg::N_DATA-1:0],
    input  logic                 data_in_valid,
    output logic                 data_in_ready,

    input  llm_int8_pkg::data_t  weight [llm_int8_pkg::N_WEIGHT-1:0],
    input  logic                 weight_valid,
    output logic                 weight_ready,

    output llm_int8_pkg::small_t small_data [llm_int8_pkg::N_DATA-1:0],
    output llm_int8_pkg::data_t  small_weight [llm_int8_pkg::N_WEIGHT-1:0],
    output logic                 small_valid,
    input  logic                 small_ready,

    output llm_int8_pkg::data_t  large_data [llm_int8_pkg::N_DATA-1:0],
    output llm_int8_pkg::data_t  large_weight [llm_int8_pkg::N_WEIGHT-1:0],
    output logic                 large_valid,
    input  logic                 large_ready
);

    llm_int8_pkg::small_t small_next [llm_int8_pkg::N_DATA-1:0];
    llm_int8_pkg::data_t  large_next [llm_int8_pkg::N_DATA-1:0];

    llm_int8_pkg::small_t small_q [llm_int8_pkg::N_DATA-1:0];
    llm_int8_pkg::data_t  large_q [llm_int8_pkg::N_DATA-1:0];
    llm_int8_pkg::data_t  weight_q [llm_int8_pkg::N_WEIGHT-1:0];

    logic small_pending;
    logic large_pending;
    logic paths_free;
    logic take;

    // element-wise split into two sparse copies
    always_comb begin
        for (int i = 0; i < llm_int8_pkg::N_DATA; i++) begin
            if (data_in[i] >= llm_int8_pkg::SMALL_MIN &&
                data_in[i] <= llm_int8_pkg::SMALL_MAX) begin
                // fits in int8, upper bits are pure sign
                small_next[i] = data_in[i][llm_int8_pkg::SMALL_WIDTH-1:0];
                large_next[i] = '0;
            end else begin
                small_next[i] = '0;
                large_next[i] = data_in[i];
            end
        end
    end

    // a path is free when empty or draining this cycle
    assign paths_free = !rst &&
                        (!small_pending || small_ready) &&
                        (!large_pending || large_ready);

    // join of data and weight, both readies rise together
    assign take = data_in_valid && weight_valid && paths_free;
    assign data_in_ready = take;
    assign weight_ready = take;

    always_ff @(posedge clk) begin
        if (take) begin
            small_q <= small_next;
            large_q <= large_next;
            weight_q <= weight;
        end
    end

    // pending flags clear independently per path
    always_ff @(posedge clk) begin
        if (rst) begin
            small_pending <= 1'b0;
            large_pending <= 1'b0;
        end else begin
            if (take) begin
                small_pending <= 1'b1;
            end else if (small_ready) begin
                small_pending <= 1'b0;
            end

            if (take) begin
                large_pending <= 1'b1;
            end else if (large_ready) begin
                large_pending <= 1'b0;
            end
        end
    end

    // weight register is shared, it holds until both paths drain
    assign small_data = small_q;
    assign small_weight = weight_q;
    assign small_valid = small_pending;

    assign large_data = large_q;
    assign large_weight = weight_q;
    assign large_valid = large_pending;

endmodule

// ==== source/matmul_core.sv ====
`timescale 1ns/10ps

// out element (r, c) sits at index r*WEIGHT_PARALLELISM + c
module matmul_core #(
    parameter type IN_T = llm_int8_pkg::data_t
) (
    input  logic                clk,
    input  logic                rst,

    input  IN_T                 in_data [llm_int8_pkg::N_DATA-1:0],
    input  llm_int8_pkg::data_t in_weight [llm_int8_pkg::N_WEIGHT-1:0],
    input  logic                in_valid,
    output logic                in_ready,

    output llm_int8_pkg::acc_t  out_data [llm_int8_pkg::N_OUT-1:0],
    output logic                out_valid,
    input  logic                out_ready
);

    llm_int8_pkg::acc_t block_sum [llm_int8_pkg::N_OUT-1:0];
    llm_int8_pkg::acc_t acc_q [llm_int8_pkg::N_OUT-1:0];
    llm_int8_pkg::acc_t result_q [llm_int8_pkg::N_OUT-1:0];

    logic [llm_int8_pkg::CNT_WIDTH-1:0] beat_q;
    logic last_beat;
    logic accept;
    logic out_valid_q;

    // products of one beat, summed over the shared dimension
    always_comb begin
        llm_int8_pkg::acc_t sum;
        for (int r = 0; r < llm_int8_pkg::IN_PARALLELISM; r++) begin
            for (int c = 0; c < llm_int8_pkg::WEIGHT_PARALLELISM; c++) begin
                sum = '0;
                for (int k = 0; k < llm_int8_pkg::IN_SIZE; k++) begin
                    // casts sign-extend both operands
                    sum = sum +
                          llm_int8_pkg::acc_t'(in_data[r * llm_int8_pkg::IN_SIZE + k]) *
                          llm_int8_pkg::acc_t'(in_weight[c * llm_int8_pkg::IN_SIZE + k]);
                end
                block_sum[r * llm_int8_pkg::WEIGHT_PARALLELISM + c] = sum;
            end
        end
    end

    assign last_beat = (beat_q == llm_int8_pkg::CNT_WIDTH'(llm_int8_pkg::IN_DEPTH - 1));

    // only the closing beat of a group needs a free result register
    assign in_ready = !last_beat || !out_valid_q || out_ready;
    assign accept = in_valid && in_ready;

    // accumulator and beat counter
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q <= '0;
            acc_q <= '{default: '0};
        end else if (accept) begin
            if (last_beat) begin
                // next group starts from zero on the following beat
                beat_q <= '0;
                acc_q <= '{default: '0};
            end else begin
                beat_q <= beat_q + 1'b1;
                for (int i = 0; i < llm_int8_pkg::N_OUT; i++) begin
                    acc_q[i] <= acc_q[i] + block_sum[i];
                end
            end
        end
    end

    // result register, loaded with the full group sum
    always_ff @(posedge clk) begin
        if (accept && last_beat) begin
            for (int i = 0; i < llm_int8_pkg::N_OUT; i++) begin
                result_q[i] <= acc_q[i] + block_sum[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (accept && last_beat) begin
            out_valid_q <= 1'b1;
        end else if (out_ready) begin
            out_valid_q <= 1'b0;
        end
    end

    assign out_data = result_q;
    assign out_valid = out_valid_q;

endmodule

// ==== source/result_gather.sv ====
`timescale 1ns/10ps

module result_gather (
    input  logic               clk,
    input  logic               rst,

    input  llm_int8_pkg::acc_t small_result [llm_int8_pkg::N_OUT-1:0],
    input  logic               small_valid,
    output logic               small_ready,

    input  llm_int8_pkg::acc_t large_result [llm_int8_pkg::N_OUT-1:0],
    input  logic               large_valid,
    output logic               large_ready,

    output llm_int8_pkg::acc_t data_out [llm_int8_pkg::N_OUT-1:0],
    output logic               data_out_valid,
    input  logic               data_out_ready
);

    llm_int8_pkg::acc_t sum_q [llm_int8_pkg::N_OUT-1:0];
    logic out_valid_q;
    logic out_free;
    logic join_both;

    // output register empty or read this cycle
    assign out_free = !out_valid_q || data_out_ready;

    // both cores hand over in the same cycle
    assign join_both = small_valid && large_valid && out_free;
    assign small_ready = join_both;
    assign large_ready = join_both;

    // partial results add back to the exact product
    always_ff @(posedge clk) begin
        if (join_both) begin
            for (int i = 0; i < llm_int8_pkg::N_OUT; i++) begin
                sum_q[i] <= small_result[i] + large_result[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (join_both) begin
            out_valid_q <= 1'b1;
        end else if (data_out_ready) begin
            out_valid_q <= 1'b0;
        end
    end

    assign data_out = sum_q;
    assign data_out_valid = out_valid_q;

endmodule

// ==== source/llm_int8.sv ====
`timescale 1ns/10ps

module llm_int8 (
    input  logic                clk,
    input  logic                rst,

    input  llm_int8_pkg::data_t data_in [llm_int8_pkg::N_DATA-1:0],
    input  logic                data_in_valid,
    output logic                data_in_ready,

    input  llm_int8_pkg::data_t weight [llm_int8_pkg::N_WEIGHT-1:0],
    input  logic                weight_valid,
    output logic                weight_ready,

    output llm_int8_pkg::acc_t  data_out [llm_int8_pkg::N_OUT-1:0],
    output logic                data_out_valid,
    input  logic                data_out_ready
);

    // split to cores
    llm_int8_pkg::small_t small_data [llm_int8_pkg::N_DATA-1:0];
    llm_int8_pkg::data_t  small_weight [llm_int8_pkg::N_WEIGHT-1:0];
    logic                 small_valid;
    logic                 small_ready;

    llm_int8_pkg::data_t  large_data [llm_int8_pkg::N_DATA-1:0];
    llm_int8_pkg::data_t  large_weight [llm_int8_pkg::N_WEIGHT-1:0];
    logic                 large_valid;
    logic                 large_ready;

    // cores to gather
    llm_int8_pkg::acc_t   small_result [llm_int8_pkg::N_OUT-1:0];
    logic                 small_result_valid;
    logic                 small_result_ready;

    llm_int8_pkg::acc_t   large_result [llm_int8_pkg::N_OUT-1:0];
    logic                 large_result_valid;
    logic                 large_result_ready;

    outlier_split split_in (
        .clk           (clk),
        .rst           (rst),
        .data_in       (data_in),
        .data_in_valid (data_in_valid),
        .data_in_ready (data_in_ready),
        .weight        (weight),
        .weight_valid  (weight_valid),
        .weight_ready  (weight_ready),
        .small_data    (small_data),
        .small_weight  (small_weight),
        .small_valid   (small_valid),
        .small_ready   (small_ready),
        .large_data    (large_data),
        .large_weight  (large_weight),
        .large_valid   (large_valid),
        .large_ready   (large_ready)
    );

    // int8 path, 8 by 16 bit multipliers
    matmul_core #(
        .IN_T (llm_int8_pkg::small_t)
    ) core_small (
        .clk       (clk),
        .rst       (rst),
        .in_data   (small_data),
        .in_weight (small_weight),
        .in_valid  (small_valid),
        .in_ready  (small_ready),
        .out_data  (small_result),
        .out_valid (small_result_valid),
        .out_ready (small_result_ready)
    );

    // outlier path at full width
    matmul_core #(
        .IN_T (llm_int8_pkg::data_t)
    ) core_large (
        .clk       (clk),
        .rst       (rst),
        .in_data   (large_data),
        .in_weight (large_weight),
        .in_valid  (large_valid),
        .in_ready  (large_ready),
        .out_data  (large_result),
        .out_valid (large_result_valid),
        .out_ready (large_result_ready)
    );

    result_gather gather_out (
        .clk            (clk),
        .rst            (rst),
        .small_result   (small_result),
        .small_valid    (small_result_valid),
        .small_ready    (small_result_ready),
        .large_result   (large_result),
        .large_valid    (large_result_valid),
        .large_ready    (large_result_ready),
        .data_out       (data_out),
        .data_out_valid (data_out_valid),
        .data_out_ready (data_out_ready)
    );

endmodule

// ==== sim/llm_int8_sva.sv ====
`timescale 1ns/10ps

module llm_int8_sva (
    input logic               clk,
    input logic               rst,
    input logic               data_in_valid,
    input logic               data_in_ready,
    input logic               weight_valid,
    input logic               weight_ready,
    input llm_int8_pkg::acc_t data_out [llm_int8_pkg::N_OUT-1:0],
    input logic               data_out_valid,
    input logic               data_out_ready
);

    logic [llm_int8_pkg::N_OUT*llm_int8_pkg::ACC_WIDTH-1:0] out_flat;
    int fail_count;

    always_comb begin
        for (int i = 0; i < llm_int8_pkg::N_OUT; i++) begin
            out_flat[i*llm_int8_pkg::ACC_WIDTH +: llm_int8_pkg::ACC_WIDTH] = data_out[i];
        end
    end

    // data and weight are joined, readies move as one
    joint_ready: assert property (@(posedge clk) disable iff (rst)
        (data_in_ready == weight_ready) &&
        (!data_in_ready || (data_in_valid && weight_valid)))
        else begin
            fail_count++;
            $error("data_in_ready and weight_ready not raised together on a joint beat");
        end

    ready_in_reset: assert property (@(posedge clk) rst |-> !data_in_ready && !weight_ready)
        else begin
            fail_count++;
            $error("input ready high while rst is high");
        end

    valid_after_reset: assert property (@(posedge clk) rst |=> !data_out_valid)
        else begin
            fail_count++;
            $error("data_out_valid high after reset");
        end

    // stalled result holds valid and value
    out_stall: assert property (@(posedge clk) disable iff (rst)
        data_out_valid && !data_out_ready |=> data_out_valid && $stable(out_flat))
        else begin
            fail_count++;
            $error("data_out changed while stalled");
        end

endmodule

bind llm_int8 llm_int8_sva sva_checks (
    .clk            (clk),
    .rst            (rst),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .weight_valid   (weight_valid),
    .weight_ready   (weight_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
);

// ==== sim/llm_int8_checker.sv ====
`timescale 1ns/10ps

module llm_int8_checker (
    input  logic                clk,
    input  logic                rst,
    input  llm_int8_pkg::data_t data_in [llm_int8_pkg::N_DATA-1:0],
    input  logic                data_in_valid,
    input  logic                data_in_ready,
    input  llm_int8_pkg::data_t weight [llm_int8_pkg::N_WEIGHT-1:0],
    input  logic                weight_valid,
    input  logic                weight_ready,
    input  llm_int8_pkg::acc_t  data_out [llm_int8_pkg::N_OUT-1:0],
    input  logic                data_out_valid,
    input  logic                data_out_ready,
    output int                  error_count,
    output int                  result_count
);

    llm_int8_pkg::data_t data_q [$];
    llm_int8_pkg::data_t weight_q [$];
    llm_int8_pkg::data_t grp_data [llm_int8_pkg::IN_DEPTH][llm_int8_pkg::N_DATA];
    llm_int8_pkg::data_t grp_weight [llm_int8_pkg::IN_DEPTH][llm_int8_pkg::N_WEIGHT];
    longint expect_q [$];
    int pairs;
    logic rst_seen;

    // full-precision dot product over the whole group
    function automatic longint ref_element(int r, int c);
        longint total;
        total = 0;
        for (int b = 0; b < llm_int8_pkg::IN_DEPTH; b++) begin
            for (int k = 0; k < llm_int8_pkg::IN_SIZE; k++) begin
                total += longint'(grp_data[b][r * llm_int8_pkg::IN_SIZE + k]) *
                         longint'(grp_weight[b][c * llm_int8_pkg::IN_SIZE + k]);
            end
        end
        return total;
    endfunction

    always @(posedge clk) begin
        longint want;
        if (rst) begin
            data_q.delete();
            weight_q.delete();
            expect_q.delete();
            pairs = 0;
            rst_seen = 1'b1;
        end else begin
            if (rst_seen && data_out_valid !== 1'b0) begin
                error_count++;
                $display("[FAIL] %0t: data_out_valid high right after reset", $time);
            end
            rst_seen = 1'b0;
            if (data_in_valid && data_in_ready) begin
                for (int i = 0; i < llm_int8_pkg::N_DATA; i++) data_q.push_back(data_in[i]);
            end
            if (weight_valid && weight_ready) begin
                for (int i = 0; i < llm_int8_pkg::N_WEIGHT; i++) weight_q.push_back(weight[i]);
            end
            // pair beats in arrival order
            while (data_q.size() >= llm_int8_pkg::N_DATA &&
                   weight_q.size() >= llm_int8_pkg::N_WEIGHT) begin
                for (int i = 0; i < llm_int8_pkg::N_DATA; i++) begin
                    grp_data[pairs][i] = data_q.pop_front();
                end
                for (int i = 0; i < llm_int8_pkg::N_WEIGHT; i++) begin
                    grp_weight[pairs][i] = weight_q.pop_front();
                end
                pairs++;
                if (pairs == llm_int8_pkg::IN_DEPTH) begin
                    for (int r = 0; r < llm_int8_pkg::IN_PARALLELISM; r++) begin
                        for (int c = 0; c < llm_int8_pkg::WEIGHT_PARALLELISM; c++) begin
                            expect_q.push_back(ref_element(r, c));
                        end
                    end
                    pairs = 0;
                end
            end
            if (data_out_valid && data_out_ready) begin
                if (expect_q.size() < llm_int8_pkg::N_OUT) begin
                    error_count++;
                    $display("[FAIL] %0t: result %0d with no complete group sent",
                             $time, result_count);
                end else begin
                    for (int i = 0; i < llm_int8_pkg::N_OUT; i++) begin
                        want = expect_q.pop_front();
                        if (longint'(data_out[i]) != want) begin
                            error_count++;
                            $display("[FAIL] %0t: result %0d element %0d is %0d, expected %0d",
                                     $time, result_count, i, data_out[i], want);
                        end
                    end
                end
                result_count++;
            end
        end
    end

endmodule

// ==== sim/llm_int8_tb.sv ====
`timescale 1ns/10ps

module llm_int8_tb;

    localparam int NUM_GROUPS = 10;
    localparam int NUM_BEATS = NUM_GROUPS * llm_int8_pkg::IN_DEPTH;
    // first groups run with no gaps and no back-pressure
    localparam int CALM_GROUPS = 3;
    localparam int TIMEOUT_CYCLES = NUM_BEATS * 20;
    localparam int SEED = 30175;

    logic clk;
    logic rst;
    llm_int8_pkg::data_t data_in [llm_int8_pkg::N_DATA-1:0];
    logic data_in_valid;
    logic data_in_ready;
    llm_int8_pkg::data_t weight [llm_int8_pkg::N_WEIGHT-1:0];
    logic weight_valid;
    logic weight_ready;
    llm_int8_pkg::acc_t data_out [llm_int8_pkg::N_OUT-1:0];
    logic data_out_valid;
    logic data_out_ready;
    int error_count;
    int result_count;
    int cycles;

    llm_int8_pkg::data_t data_beats [NUM_BEATS][llm_int8_pkg::N_DATA];
    llm_int8_pkg::data_t weight_beats [NUM_BEATS][llm_int8_pkg::N_WEIGHT];

    llm_int8 UUT (.*);
    llm_int8_checker checks (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: stopped waiting for results, %0d of %0d arrived",
                     result_count, NUM_GROUPS);
            $display("Test failed");
            $finish;
        end
    end

    // kind 0 int8 range, 1 outlier, 2 split boundary, 3 any of these
    function automatic llm_int8_pkg::data_t pick_value(int kind);
        int sel;
        int mag;
        sel = (kind == 3) ? int'($urandom_range(2)) : kind;
        mag = int'($urandom_range(32767, 128));
        if (sel == 0) return llm_int8_pkg::data_t'(int'($urandom_range(255)) - 128);
        if (sel == 1) return llm_int8_pkg::data_t'(($urandom_range(1) == 1) ? -(mag + 1) : mag);
        // -129, -128, 127 or 128
        mag = int'($urandom_range(3));
        return llm_int8_pkg::data_t'((mag < 2) ? mag - 129 : mag + 125);
    endfunction

    task automatic build_stimulus();
        for (int b = 0; b < NUM_BEATS; b++) begin
            for (int i = 0; i < llm_int8_pkg::N_DATA; i++) begin
                data_beats[b][i] = pick_value((b / llm_int8_pkg::IN_DEPTH < 3) ?
                                              b / llm_int8_pkg::IN_DEPTH : 3);
            end
            for (int i = 0; i < llm_int8_pkg::N_WEIGHT; i++) begin
                weight_beats[b][i] = llm_int8_pkg::data_t'($urandom);
            end
        end
        // full-scale extremes in the outlier group
        data_beats[llm_int8_pkg::IN_DEPTH][0] = 16'sh8000;
        data_beats[llm_int8_pkg::IN_DEPTH][1] = 16'sh7fff;
        weight_beats[llm_int8_pkg::IN_DEPTH][0] = 16'sh8000;
        weight_beats[llm_int8_pkg::IN_DEPTH][1] = 16'sh7fff;
    endtask

    task automatic drive_data();
        for (int b = 0; b < NUM_BEATS; b++) begin
            if (b >= CALM_GROUPS * llm_int8_pkg::IN_DEPTH) begin
                repeat ($urandom_range(2)) @(negedge clk);
            end
            for (int i = 0; i < llm_int8_pkg::N_DATA; i++) data_in[i] = data_beats[b][i];
            data_in_valid = 1'b1;
            do @(posedge clk); while (!data_in_ready);
            @(negedge clk);
            data_in_valid = 1'b0;
        end
    endtask

    task automatic drive_weight();
        for (int b = 0; b < NUM_BEATS; b++) begin
            if (b >= CALM_GROUPS * llm_int8_pkg::IN_DEPTH) begin
                repeat ($urandom_range(2)) @(negedge clk);
            end
            for (int i = 0; i < llm_int8_pkg::N_WEIGHT; i++) weight[i] = weight_beats[b][i];
            weight_valid = 1'b1;
            do @(posedge clk); while (!weight_ready);
            @(negedge clk);
            weight_valid = 1'b0;
        end
    endtask

    task automatic drive_out_ready();
        while (result_count < NUM_GROUPS) begin
            @(negedge clk);
            data_out_ready = (result_count < CALM_GROUPS) || ($urandom_range(1) == 1);
        end
    endtask

    initial begin
        int missing;
        int sva_fails;
        void'($urandom(SEED));
        clk = 1'b0;
        rst = 1'b1;
        // input ready has to stay low in reset even with both valids up
        data_in_valid = 1'b1;
        weight_valid = 1'b1;
        data_out_ready = 1'b0;
        for (int i = 0; i < llm_int8_pkg::N_DATA; i++) data_in[i] = '0;
        for (int i = 0; i < llm_int8_pkg::N_WEIGHT; i++) weight[i] = '0;
        build_stimulus();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        data_in_valid = 1'b0;
        weight_valid = 1'b0;
        fork
            drive_data();
            drive_weight();
            drive_out_ready();
        join
        data_out_ready = 1'b1;
        // idle time exposes a repeated result
        repeat (10) @(negedge clk);
        missing = (result_count < NUM_GROUPS) ? NUM_GROUPS - result_count : 0;
        sva_fails = UUT.sva_checks.fail_count;
        $display("%0d of %0d results, %0d check errors, %0d missing, %0d assertion failures",
                 result_count, NUM_GROUPS, error_count, missing, sva_fails);
        if (error_count + missing + sva_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== llm_int8.f ====
source/llm_int8_pkg.sv
source/outlier_split.sv
source/matmul_core.sv
source/result_gather.sv
source/llm_int8.sv
sim/llm_int8_sva.sv
sim/llm_int8_checker.sv
sim/llm_int8_tb.sv

// ==== Makefile ====
# Verilator flow for the LLM.int8 matmul block
VERILATOR   ?= verilator
TOP         ?= llm_int8_tb
FILELIST    ?= llm_int8.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
PASS_MSG    ?= Test completed successfully
LINT_FLAGS  ?= --lint-only --timing --assert
BUILD_FLAGS ?= --binary --timing --assert -j 0
# keep running after an assertion error so the testbench can report
RUN_ARGS    ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "sim: PASS" || (echo "sim: FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
